// ==== ncpu_irq_line.sv ====
// Interrupt line cell: two-flop synchronizer, mask bit and pending bit
`timescale 1ns/1ns
`default_nettype none

module ncpu_irq_line (
   input  wire  clk,
   input  wire  rst_n,
   input  wire  irq_lvl,
   input  wire  mask_we,
   input  wire  mask_wdata,
   output logic mask,
   output logic pending
);

   logic sync_q1;
   logic sync_q2;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         sync_q1 <= 1'b0;
         sync_q2 <= 1'b0;
      end else begin
         sync_q1 <= irq_lvl;              // Async level in
         sync_q2 <= sync_q1;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         mask <= 1'b1;                    // Line masked out of reset
      end else if (mask_we) begin
         mask <= mask_wdata;
      end
   end

   assign pending = sync_q2 & ~mask;

   // Masking a line silences it from the very next cycle,
   // whatever the synchronizer still holds
   a_mask_silences: assert property (
      @(posedge clk) disable iff (!rst_n)
      mask_we && mask_wdata |=> !pending
   );

endmodule

`default_nettype wire

// ==== ncpu_irq_merge.sv ====
// Interrupt merge: registered irq_sync, IMR/IRR assembly and MSR read mux
`timescale 1ns/1ns
`default_nettype none

module ncpu_irq_merge #(
   parameter int NIRQ = 32
) (
   input  wire                                  clk,
   input  wire                                  rst_n,
   input  wire [NIRQ-1:0]                       pending,
   input  wire [NIRQ-1:0]                       mask,
   input  wire                                  psr_ire,
   input  wire [ncpu_tsc_pkg::TSR_W-1:0]        tsr,
   input  wire ncpu_tsc_pkg::tcr_t              tcr,
   input  wire ncpu_msr_pkg::msr_addr_e         msr_raddr,
   output logic [ncpu_msr_pkg::DW-1:0]          msr_rdata,
   output logic                                 irq_sync
);
   import ncpu_msr_pkg::*;

   logic [DW-1:0] imr;
   logic [DW-1:0] irr;

   // Unused upper lines read as zero
   assign imr = DW'(mask);
   assign irr = DW'(pending);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         irq_sync <= 1'b0;
      end else begin
         irq_sync <= psr_ire & (|pending);  // Global enable from PSR
      end
   end

   always_comb begin
      case (msr_raddr)
         MSR_IMR: msr_rdata = imr;
         MSR_IRR: msr_rdata = irr;
         MSR_TSR: msr_rdata = DW'(tsr);
         MSR_TCR: msr_rdata = DW'(tcr);
         default: msr_rdata = '0;
      endcase
   end

endmodule

`default_nettype wire

// ==== ncpu_irq_subsys.sv ====
// Interrupt and timer subsystem top: MSR decoder, line cells, merge and TSC
`timescale 1ns/1ns
`default_nettype none

module ncpu_irq_subsys #(
   parameter int NIRQ         = 32,   // At most the MSR data width
   parameter int TSC_IRQ_LINE = 0
) (
   input  wire                                  clk,
   input  wire                                  rst_n,
   input  wire ncpu_msr_pkg::msr_wr_t           msr_wr,
   input  wire ncpu_msr_pkg::msr_addr_e         msr_raddr,
   output logic [ncpu_msr_pkg::DW-1:0]          msr_rdata,
   input  wire [NIRQ-1:0]                       irqs,
   input  wire                                  psr_ire,
   output logic                                 irq_sync
);
   import ncpu_msr_pkg::*;
   import ncpu_tsc_pkg::*;

   logic [NIRQ-1:0]  imr_we;
   logic [NIRQ-1:0]  imr_wdata;
   logic             tsr_we;
   logic             tcr_we;
   logic [DW-1:0]    wdata;
   logic [NIRQ-1:0]  irq_lvl;              // irqs with the timer merged in
   logic [NIRQ-1:0]  mask;
   logic [NIRQ-1:0]  pending;
   logic [TSR_W-1:0] tsr;
   tcr_t             tcr;

   ncpu_msr_decode #(.NIRQ(NIRQ)) u_msr_decode (
      .clk       (clk),
      .rst_n     (rst_n),
      .msr_wr    (msr_wr),
      .imr_we    (imr_we),
      .imr_wdata (imr_wdata),
      .tsr_we    (tsr_we),
      .tcr_we    (tcr_we),
      .wdata     (wdata)
   );

   for (genvar i = 0; i < NIRQ; i++) begin : g_line
      ncpu_irq_line u_line (
         .clk        (clk),
         .rst_n      (rst_n),
         .irq_lvl    (irq_lvl[i]),
         .mask_we    (imr_we[i]),
         .mask_wdata (imr_wdata[i]),
         .mask       (mask[i]),
         .pending    (pending[i])
      );
   end

   ncpu_irq_merge #(.NIRQ(NIRQ)) u_irq_merge (
      .clk       (clk),
      .rst_n     (rst_n),
      .pending   (pending),
      .mask      (mask),
      .psr_ire   (psr_ire),
      .tsr       (tsr),
      .tcr       (tcr),
      .msr_raddr (msr_raddr),
      .msr_rdata (msr_rdata),
      .irq_sync  (irq_sync)
   );

   ncpu_tsc #(
      .NIRQ         (NIRQ),
      .TSC_IRQ_LINE (TSC_IRQ_LINE)
   ) u_tsc (
      .clk     (clk),
      .rst_n   (rst_n),
      .tsr_we  (tsr_we),
      .tcr_we  (tcr_we),
      .wdata   (wdata),
      .irqs    (irqs),
      .tsr     (tsr),
      .tcr     (tcr),
      .irq_lvl (irq_lvl)
   );

endmodule

`default_nettype wire

// ==== ncpu_msr_decode.sv ====
// MSR write decoder: per-register write strobes and per-line mask writes
`timescale 1ns/1ns
`default_nettype none

module ncpu_msr_decode #(
   parameter int NIRQ = 32
) (
   input  wire                              clk,
   input  wire                              rst_n,
   input  wire ncpu_msr_pkg::msr_wr_t       msr_wr,
   output logic [NIRQ-1:0]                  imr_we,
   output logic [NIRQ-1:0]                  imr_wdata,
   output logic                             tsr_we,
   output logic                             tcr_we,
   output logic [ncpu_msr_pkg::DW-1:0]      wdata
);
   import ncpu_msr_pkg::*;

   logic imr_sel;

   always_comb begin
      imr_sel = 1'b0;
      tsr_we  = 1'b0;
      tcr_we  = 1'b0;
      if (msr_wr.valid) begin
         case (msr_wr.addr)
            MSR_IMR: imr_sel = 1'b1;
            MSR_TSR: tsr_we  = 1'b1;
            MSR_TCR: tcr_we  = 1'b1;
            default: ;                   // IRR is read only
         endcase
      end
   end

   // Every line cell sees the same strobe and picks its own data bit
   assign imr_we    = {NIRQ{imr_sel}};
   assign imr_wdata = msr_wr.data[NIRQ-1:0];
   assign wdata     = msr_wr.data;       // Shared by TSR and TCR

   // The master keeps the port idle while reset is held
   a_no_wr_in_reset: assert property (
      @(posedge clk) !rst_n |-> !msr_wr.valid
   );

   a_one_target: assert property (
      @(posedge clk) disable iff (!rst_n)
      $onehot0({|imr_we, tsr_we, tcr_we})
   );

endmodule

`default_nettype wire

// ==== ncpu_msr_pkg.sv ====
// MSR data width, MSR register select enum and MSR write request struct
`default_nettype none

package ncpu_msr_pkg;

   // Width of an MSR data word
   localparam int DW = 32;

   // Register selects on the MSR port
   typedef enum logic [1:0] {
      MSR_IMR = 2'd0,  // Interrupt mask, one bit per line
      MSR_IRR = 2'd1,  // Interrupt pending, read only
      MSR_TSR = 2'd2,  // Timestamp count
      MSR_TCR = 2'd3   // Timestamp control
   } msr_addr_e;

   // One write request from the backend side
   typedef struct packed {
      logic            valid;  // Single-cycle strobe
      msr_addr_e       addr;
      logic [DW-1:0]   data;
   } msr_wr_t;

endpackage

`default_nettype wire

// ==== ncpu_tsc.sv ====
// Timestamp counter with TSR, TCR, compare interrupt and IRQ line routing
`timescale 1ns/1ns
`default_nettype none

module ncpu_tsc #(
   parameter int NIRQ         = 32,
   parameter int TSC_IRQ_LINE = 0
) (
   input  wire                                  clk,
   input  wire                                  rst_n,
   input  wire                                  tsr_we,
   input  wire                                  tcr_we,
   input  wire [ncpu_msr_pkg::DW-1:0]           wdata,
   input  wire [NIRQ-1:0]                       irqs,
   output logic [ncpu_tsc_pkg::TSR_W-1:0]       tsr,
   output ncpu_tsc_pkg::tcr_t                   tcr,
   output logic [NIRQ-1:0]                      irq_lvl
);
   import ncpu_tsc_pkg::*;

   logic tsc_irq;
   logic cmp_hit;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         tsr <= '0;
      end else if (tsr_we) begin
         tsr <= TSR_W'(wdata);            // Write wins over the increment
      end else if (tcr.en) begin
         tsr <= tsr + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         tcr <= '0;
      end else if (tcr_we) begin
         tcr <= tcr_t'(wdata);
      end
   end

   assign cmp_hit = tcr.ien && (tsr[CMP_W-1:0] == tcr.cmp);

   // Sticky until software touches TCR
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         tsc_irq <= 1'b0;
      end else if (tcr_we) begin
         tsc_irq <= 1'b0;
      end else if (cmp_hit) begin
         tsc_irq <= 1'b1;
      end
   end

   always_comb begin
      irq_lvl               = irqs;
      irq_lvl[TSC_IRQ_LINE] = irqs[TSC_IRQ_LINE] | tsc_irq;  // Shares the line
   end

   a_irq_needs_ien: assert property (
      @(posedge clk) disable iff (!rst_n)
      $rose(tsc_irq) |-> $past(tcr.ien)
   );

endmodule

`default_nettype wire

// ==== ncpu_tsc_pkg.sv ====
// Timestamp counter width, compare width and TCR layout
`default_nettype none

package ncpu_tsc_pkg;

   // Width of the count register
   localparam int TSR_W = 32;

   // Compare field covers the low bits of TSR only
   localparam int CMP_W = 28;

   // Timestamp control register, en in the top bit
   typedef struct packed {
      logic             en;        // Counter runs
      logic             ien;       // Compare interrupt enabled
      logic [1:0]       reserved;
      logic [CMP_W-1:0] cmp;       // Matched against TSR[CMP_W-1:0]
   } tcr_t;

endpackage

`default_nettype wire

// ==== src.f ====
ncpu_msr_pkg.sv
ncpu_tsc_pkg.sv
ncpu_msr_decode.sv
ncpu_irq_line.sv
ncpu_irq_merge.sv
ncpu_tsc.sv
ncpu_irq_subsys.sv
tb_ncpu_irq_subsys.sv

// ==== tb_ncpu_irq_subsys.sv ====
// Testbench for the interrupt and timer subsystem: stimulus, reference model, checks, report
`timescale 1ns/1ns
`default_nettype none

module tb_ncpu_irq_subsys;
   import ncpu_msr_pkg::*;
   import ncpu_tsc_pkg::*;

   localparam int NIRQ       = 32;
   localparam int TSC_LINE   = 0;     // DUT default for TSC_IRQ_LINE
   localparam int PERIOD     = 20;
   localparam int RST_CYC    = 5;
   localparam int QUIET_CYC  = 40;
   localparam int IMR_WR     = 20;
   localparam int IRQ_ROUNDS = 16;
   localparam int HOLD_CYC   = 6;
   localparam int RUN_CYC    = 20;
   localparam int TOTAL_CYC  = RST_CYC + QUIET_CYC + 2 * IMR_WR + 16
                               + IRQ_ROUNDS * (HOLD_CYC + 3) + 3 * RUN_CYC + 50;
   localparam int MARGIN_CYC = 100;

   logic            clk = 1'b0;
   logic            rst_n;
   msr_wr_t         msr_wr;
   msr_addr_e       msr_raddr;
   logic [DW-1:0]   msr_rdata;
   logic [NIRQ-1:0] irqs;
   logic            psr_ire;
   logic            irq_sync;

   // Reference model state
   logic [NIRQ-1:0] m_imr;
   logic [TSR_W-1:0] m_tsr;
   tcr_t            m_tcr;
   logic            m_flag;
   logic [NIRQ-1:0] m_lvl;
   logic [NIRQ-1:0] m_s1;
   logic [NIRQ-1:0] m_s2;
   logic [NIRQ-1:0] m_irr;
   logic            m_irq;
   logic [DW-1:0]   exp_rdata;

   logic            expect_tsc;
   string           test_name;
   int              test_errs;
   int              n_errors;
   int              n_tests;
   int              n_bad_tests;

   ncpu_irq_subsys u_dut (
      .clk       (clk),
      .rst_n     (rst_n),
      .msr_wr    (msr_wr),
      .msr_raddr (msr_raddr),
      .msr_rdata (msr_rdata),
      .irqs      (irqs),
      .psr_ire   (psr_ire),
      .irq_sync  (irq_sync)
   );

   always #(PERIOD / 2) clk = ~clk;

   always_comb begin
      m_lvl           = irqs;
      m_lvl[TSC_LINE] = irqs[TSC_LINE] | m_flag;  // Timer shares its line
      m_irr           = m_s2 & ~m_imr;
   end

   always_comb begin
      case (msr_raddr)
         MSR_IMR: exp_rdata = DW'(m_imr);
         MSR_IRR: exp_rdata = DW'(m_irr);
         MSR_TSR: exp_rdata = DW'(m_tsr);
         default: exp_rdata = DW'(m_tcr);
      endcase
   end

   always @(posedge clk) begin
      if (!rst_n) begin
         m_imr  <= '1;
         m_tsr  <= '0;
         m_tcr  <= '0;
         m_flag <= 1'b0;
         m_s1   <= '0;
         m_s2   <= '0;
         m_irq  <= 1'b0;
      end else begin
         m_s1  <= m_lvl;
         m_s2  <= m_s1;
         m_irq <= psr_ire & (|m_irr);
         if (msr_wr.valid && msr_wr.addr == MSR_IMR)
            m_imr <= msr_wr.data[NIRQ-1:0];
         if (msr_wr.valid && msr_wr.addr == MSR_TCR)
            m_tcr <= tcr_t'(msr_wr.data);
         if (msr_wr.valid && msr_wr.addr == MSR_TSR)
            m_tsr <= msr_wr.data;
         else if (m_tcr.en)
            m_tsr <= m_tsr + 1'b1;
         if (msr_wr.valid && msr_wr.addr == MSR_TCR)
            m_flag <= 1'b0;                        // Any TCR write clears it
         else if (m_tcr.ien && m_tsr[CMP_W-1:0] == m_tcr.cmp)
            m_flag <= 1'b1;
      end
   end

   function automatic void report_mismatch(input string what, input logic [DW-1:0] exp,
                                           input logic [DW-1:0] act);
      test_errs++;
      n_errors++;
      $display("mismatch %s %s expected %h actual %h", test_name, what, exp, act);
   endfunction

   a_rdata: assert property (@(posedge clk) disable iff (!rst_n) msr_rdata == exp_rdata)
      else report_mismatch("msr_rdata", $sampled(exp_rdata), $sampled(msr_rdata));

   a_irq_sync: assert property (@(posedge clk) disable iff (!rst_n) irq_sync == m_irq)
      else report_mismatch("irq_sync", DW'($sampled(m_irq)), DW'($sampled(irq_sync)));

   // Timer compare must show up on its IRR bit once it has had time to travel
   a_tsc_pends: assert property (@(posedge clk) disable iff (!rst_n)
      expect_tsc && msr_raddr == MSR_IRR |-> msr_rdata[TSC_LINE])
      else report_mismatch("irr_tsc_bit", 32'd1, DW'($sampled(msr_rdata[TSC_LINE])));

   task automatic start_test(input string name);
      test_name = name;
      test_errs = 0;
   endtask

   task automatic finish_test();
      #1;                                          // Let this edge's checks land
      n_tests++;
      if (test_errs != 0)
         n_bad_tests++;
      $display("test %-10s %s, %0d errors", test_name, (test_errs == 0) ? "ok" : "FAILED",
               test_errs);
   endtask

   task automatic write_msr(input msr_addr_e addr, input logic [DW-1:0] data);
      @(posedge clk);
      msr_wr    <= '{valid: 1'b1, addr: addr, data: data};
      msr_raddr <= addr;
      @(posedge clk);
      msr_wr    <= '0;                             // Single-cycle strobe
   endtask

   // raddr below zero picks a random register each cycle
   task automatic idle_cycles(input int n, input bit toggle_irqs, input int raddr);
      repeat (n) begin
         @(posedge clk);
         if (toggle_irqs)
            irqs <= NIRQ'($urandom);
         if (raddr < 0)
            msr_raddr <= msr_addr_e'($urandom_range(3, 0));
         else
            msr_raddr <= msr_addr_e'(raddr[1:0]);
      end
   endtask

   initial begin
      #((TOTAL_CYC + MARGIN_CYC) * PERIOD);
      $display("watchdog: simulation ran past its time limit");
      $display("tests failed");
      $finish;
   end

   initial begin
      void'($urandom(32'ha8d6));
      rst_n      = 1'b0;
      msr_wr     = '0;
      msr_raddr  = MSR_IMR;
      irqs       = '0;
      psr_ire    = 1'b0;
      expect_tsc = 1'b0;
      n_errors   = 0;
      n_tests    = 0;
      n_bad_tests = 0;
      repeat (RST_CYC) @(posedge clk);
      rst_n   <= 1'b1;
      psr_ire <= 1'b1;

      start_test("reset");
      idle_cycles(QUIET_CYC, 1'b1, -1);            // All lines masked, so irq_sync stays low
      finish_test();

      start_test("imr_rw");
      repeat (IMR_WR) write_msr(MSR_IMR, $urandom);
      repeat (5) write_msr(MSR_IRR, $urandom);     // Read only, nothing may move
      idle_cycles(2, 1'b0, int'(MSR_IMR));
      idle_cycles(2, 1'b0, int'(MSR_TSR));
      idle_cycles(2, 1'b0, int'(MSR_TCR));
      finish_test();

      start_test("irq_path");
      repeat (IRQ_ROUNDS) begin
         @(posedge clk);
         irqs    <= NIRQ'($urandom);
         psr_ire <= $urandom_range(1, 0);
         write_msr(MSR_IMR, $urandom);
         idle_cycles(HOLD_CYC, 1'b0, int'(MSR_IRR));
      end
      finish_test();

      start_test("tsr_count");
      write_msr(MSR_TCR, 32'h8000_0000);           // en only
      idle_cycles(RUN_CYC, 1'b0, int'(MSR_TSR));
      write_msr(MSR_TSR, $urandom);                // Overrides the increment
      idle_cycles(RUN_CYC, 1'b0, int'(MSR_TSR));
      write_msr(MSR_TCR, 32'h0);
      idle_cycles(5, 1'b0, -1);
      finish_test();

      start_test("tsc_irq");
      @(posedge clk);
      irqs    <= '0;
      psr_ire <= 1'b1;
      write_msr(MSR_IMR, ~(32'h1 << TSC_LINE));
      write_msr(MSR_TSR, 32'd100);
      write_msr(MSR_TCR, {2'b11, 2'b00, 28'd108});  // en, ien, cmp 8 ahead
      idle_cycles(16, 1'b0, int'(MSR_IRR));
      @(posedge clk);
      expect_tsc <= 1'b1;
      idle_cycles(4, 1'b0, int'(MSR_IRR));
      @(posedge clk);
      expect_tsc <= 1'b0;
      write_msr(MSR_TCR, {2'b10, 2'b00, m_tsr[CMP_W-1:0] + 28'd5});  // ien clear
      idle_cycles(RUN_CYC, 1'b0, int'(MSR_IRR));
      finish_test();

      $display("summary: %0d tests run, %0d with errors, %0d checks wrong",
               n_tests, n_bad_tests, n_errors);
      if (n_errors == 0)
         $display("all tests passed");
      else
         $display("tests failed");
      $finish;
   end

endmodule

`default_nettype wire
